/* logic/dfp_pkg.sv */
package dfp_pkg;

	// ========================================================================
	// Encodings shared by the decimal add/sub pipeline
	// ========================================================================

	// Opcode presented alongside the operands
	typedef enum logic {
		op_add = 1'b0,
		op_sub = 1'b1
	} dfp_op_e;

	// Rounding mode, travels down the pipe with its operation
	typedef enum logic [1:0] {
		rm_nearest_even = 2'd0,
		rm_toward_zero  = 2'd1,
		rm_toward_pos   = 2'd2,
		rm_toward_neg   = 2'd3
	} dfp_rm_e;

	// ========================================================================
	// Datapath widths
	// ========================================================================

	// One packed BCD digit
	localparam int BCD_DIGIT_W = 4;

	// Guard and round digits kept below the significand while working
	// The sticky digit rides separately as a single flag
	localparam int WORK_DIGITS_EXTRA = 2;

	// Special exponent is all ones of the exponent field
	// Each module builds it from its own EXP_W parameter

endpackage

/* logic/bcd_add_sub.sv */
`timescale 1ns/1ps

module bcd_add_sub import dfp_pkg::*; #(
	parameter int DIGITS = 7
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic sub,
	input  logic [(DIGITS+WORK_DIGITS_EXTRA)*BCD_DIGIT_W-1:0] x,
	input  logic [(DIGITS+WORK_DIGITS_EXTRA)*BCD_DIGIT_W-1:0] y,
	output logic [(DIGITS+WORK_DIGITS_EXTRA+1)*BCD_DIGIT_W-1:0] s
);

	// Working digits are the significand plus guard and round
	localparam int N = DIGITS + WORK_DIGITS_EXTRA;
	localparam int W = N * BCD_DIGIT_W;

	logic [W-1:0] digits;
	logic [N:0]   carry;

	// ========================================================================
	// Unrolled digit-serial decimal add
	// ========================================================================

	// Subtract is x + nines(y) + 1, so the carry chain starts at sub
	// Each digit sum above 9 wraps by adding 6 and passes a carry up
	always_comb begin
		logic [BCD_DIGIT_W-1:0] yd;
		logic [BCD_DIGIT_W:0]   t;
		carry[0] = sub;
		for (int i = 0; i < N; i++) begin
			// Nine's complement of the y digit on subtract
			if (sub) begin
				yd = 4'd9 - y[i*BCD_DIGIT_W +: BCD_DIGIT_W];
			end else begin
				yd = y[i*BCD_DIGIT_W +: BCD_DIGIT_W];
			end
			t = {1'b0, x[i*BCD_DIGIT_W +: BCD_DIGIT_W]} + {1'b0, yd} + carry[i];
			if (t > 5'd9) begin
				// Decimal correction
				digits[i*BCD_DIGIT_W +: BCD_DIGIT_W] = t[BCD_DIGIT_W-1:0] + 4'd6;
				carry[i+1] = 1'b1;
			end else begin
				digits[i*BCD_DIGIT_W +: BCD_DIGIT_W] = t[BCD_DIGIT_W-1:0];
				carry[i+1] = 1'b0;
			end
		end
	end

	// ========================================================================
	// Result register
	// ========================================================================

	// x is the larger magnitude, so a subtract never borrows out
	// Its end carry is only the complement artefact and gets dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			s <= '0;
		end else if (ce) begin
			s <= {{(BCD_DIGIT_W-1){1'b0}}, carry[N] & ~sub, digits};
		end
	end

	// Valid BCD in must give valid BCD out on every working digit
	for (genvar g = 0; g < N; g++) begin : g_digit_chk
		assert property (@(posedge clk) disable iff (rst)
			s[g*BCD_DIGIT_W +: BCD_DIGIT_W] <= 4'd9);
	end

endmodule

/* logic/dfp_align.sv */
`timescale 1ns/1ps

module dfp_align import dfp_pkg::*; #(
	parameter int DIGITS = 7,
	parameter int EXP_W  = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic [EXP_W-1:0] a_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] a_sig,
	input  logic [EXP_W-1:0] b_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] b_sig,
	output logic [(DIGITS+WORK_DIGITS_EXTRA)*BCD_DIGIT_W-1:0] big_sig,
	output logic [(DIGITS+WORK_DIGITS_EXTRA)*BCD_DIGIT_W-1:0] small_sig,
	output logic [EXP_W-1:0] big_exp,
	output logic a_is_big,
	output logic shifted_sticky
);

	localparam int SIG_W  = DIGITS * BCD_DIGIT_W;
	localparam int WRK_W  = (DIGITS + WORK_DIGITS_EXTRA) * BCD_DIGIT_W;
	localparam int MAX_SH = DIGITS + WORK_DIGITS_EXTRA;
	localparam int SH_W   = $clog2(MAX_SH + 1);

	logic a_zero;
	logic b_zero;
	logic a_wins;
	logic [EXP_W-1:0] diff;

	// Stage 2 state
	logic [SIG_W-1:0] big2;
	logic [SIG_W-1:0] small2;
	logic [EXP_W-1:0] bexp2;
	logic             a_big2;
	logic [SH_W-1:0]  sh2;

	// Smaller operand with room below for the digits shifted out
	logic [2*WRK_W-1:0] wide;

	// ========================================================================
	// Stage 2 magnitude compare and exponent difference
	// ========================================================================

	assign a_zero = (a_sig == '0);
	assign b_zero = (b_sig == '0);

	// A zero significand never wins whatever its exponent
	// Otherwise the exponent decides first and the significand breaks a tie
	// Equal magnitudes keep a as the larger one
	assign a_wins = b_zero ||
		(!a_zero && ((a_exp > b_exp) || ((a_exp == b_exp) && (a_sig >= b_sig))));

	assign diff = a_wins ? (a_exp - b_exp) : (b_exp - a_exp);

	always_ff @(posedge clk) begin
		if (rst) begin
			big2   <= '0;
			small2 <= '0;
			bexp2  <= '0;
			a_big2 <= 1'b0;
			sh2    <= '0;
		end else if (ce) begin
			big2   <= a_wins ? a_sig : b_sig;
			small2 <= a_wins ? b_sig : a_sig;
			bexp2  <= a_wins ? a_exp : b_exp;
			a_big2 <= a_wins;
			// Past the guard and round digits every digit lands in sticky
			sh2    <= (diff > MAX_SH) ? SH_W'(MAX_SH) : SH_W'(diff);
		end
	end

	// ========================================================================
	// Stage 3 right shift by whole digits and sticky collection
	// ========================================================================

	// Upper half is the aligned operand and lower half is what fell off
	assign wide = {small2, {(WORK_DIGITS_EXTRA*BCD_DIGIT_W){1'b0}}, {WRK_W{1'b0}}}
		>> (sh2 * BCD_DIGIT_W);

	always_ff @(posedge clk) begin
		if (rst) begin
			big_sig        <= '0;
			small_sig      <= '0;
			big_exp        <= '0;
			a_is_big       <= 1'b0;
			shifted_sticky <= 1'b0;
		end else if (ce) begin
			big_sig        <= {big2, {(WORK_DIGITS_EXTRA*BCD_DIGIT_W){1'b0}}};
			small_sig      <= wide[2*WRK_W-1:WRK_W];
			big_exp        <= bexp2;
			a_is_big       <= a_big2;
			shifted_sticky <= |wide[WRK_W-1:0];
		end
	end

	// A zero never ends up as the larger of a zero and a nonzero operand
	assert property (@(posedge clk) disable iff (rst)
		(big_sig == '0) |-> ((small_sig == '0) && !shifted_sticky));

endmodule

/* logic/dfp_addsub.sv */
`timescale 1ns/1ps

module dfp_addsub import dfp_pkg::*; #(
	parameter int DIGITS = 7,
	parameter int EXP_W  = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  dfp_op_e op,
	input  dfp_rm_e rm,
	input  logic a_sign,
	input  logic [EXP_W-1:0] a_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] a_sig,
	input  logic b_sign,
	input  logic [EXP_W-1:0] b_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] b_sig,
	output logic w_sign,
	output logic [EXP_W-1:0] w_exp,
	output logic [(DIGITS+WORK_DIGITS_EXTRA+1)*BCD_DIGIT_W-1:0] w_sig,
	output logic w_sticky,
	output logic w_special,
	output dfp_rm_e w_rm
);

	localparam int SIG_W  = DIGITS * BCD_DIGIT_W;
	localparam int WRK_W  = (DIGITS + WORK_DIGITS_EXTRA) * BCD_DIGIT_W;
	localparam int W_W    = WRK_W + BCD_DIGIT_W;
	localparam logic [EXP_W-1:0] SPECIAL_EXP = '1;
	// NaN is significand 1, sitting just above guard and round
	localparam logic [W_W-1:0] NAN_SIG = W_W'(1) << (WORK_DIGITS_EXTRA * BCD_DIGIT_W);
	// Side bits: a sign, effective b sign, effective sub, rm, nan, a inf, b inf
	localparam int SIDE_W   = 8;
	localparam int SIDE_SUB = 5;

	logic a_nan, a_inf, b_nan, b_inf;
	logic [EXP_W-1:0] a_exp1, b_exp1, exp4;
	logic [SIG_W-1:0] a_sig1, b_sig1;
	logic [SIDE_W-1:0] side1, side2, side3, side4;
	logic [WRK_W-1:0] big_sig3, small_sig3;
	logic [EXP_W-1:0] big_exp3;
	logic a_big3, sticky3, a_big4, sticky4;
	logic [W_W-1:0] sum;
	logic a_sign4, b_sign4, sub4, nan4, a_inf4, b_inf4;
	logic [1:0] rm4;
	logic r_sign, r_sticky, r_special;
	logic [EXP_W-1:0] r_exp;
	logic [W_W-1:0] r_sig;

	// Knock one unit off the round digit
	function automatic logic [W_W-1:0] bcd_dec(input logic [W_W-1:0] v);
		logic [W_W-1:0] r;
		logic borrow;
		r = v;
		borrow = 1'b1;
		for (int i = 0; i < W_W / BCD_DIGIT_W; i++) begin
			if (borrow) begin
				if (v[i*BCD_DIGIT_W +: BCD_DIGIT_W] == '0) begin
					r[i*BCD_DIGIT_W +: BCD_DIGIT_W] = 4'd9;
				end else begin
					r[i*BCD_DIGIT_W +: BCD_DIGIT_W] = v[i*BCD_DIGIT_W +: BCD_DIGIT_W] - 1'b1;
					borrow = 1'b0;
				end
			end
		end
		return r;
	endfunction

	// ========================================================================
	// Stage 1: operands, classification, effective operation
	// ========================================================================

	assign a_nan = (a_exp == SPECIAL_EXP) && (a_sig != '0);
	assign a_inf = (a_exp == SPECIAL_EXP) && (a_sig == '0);
	assign b_nan = (b_exp == SPECIAL_EXP) && (b_sig != '0);
	assign b_inf = (b_exp == SPECIAL_EXP) && (b_sig == '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			a_exp1 <= '0;
			a_sig1 <= '0;
			b_exp1 <= '0;
			b_sig1 <= '0;
			side1  <= '0;
		end else if (ce) begin
			a_exp1 <= a_exp;
			a_sig1 <= a_sig;
			b_exp1 <= b_exp;
			b_sig1 <= b_sig;
			// Subtract flips b; unlike effective signs mean a magnitude subtract
			side1  <= {a_sign, b_sign ^ (op == op_sub), a_sign ^ b_sign ^ (op == op_sub),
				rm, a_nan | b_nan, a_inf, b_inf};
		end
	end

	// Side bits follow the datapath through stages 2 to 4
	always_ff @(posedge clk) begin
		if (rst) begin
			side2   <= '0;
			side3   <= '0;
			side4   <= '0;
			exp4    <= '0;
			a_big4  <= 1'b0;
			sticky4 <= 1'b0;
		end else if (ce) begin
			side2   <= side1;
			side3   <= side2;
			side4   <= side3;
			exp4    <= big_exp3;
			a_big4  <= a_big3;
			sticky4 <= sticky3;
		end
	end

	// Stages 2 and 3
	dfp_align #(.DIGITS(DIGITS), .EXP_W(EXP_W)) dfp_align_inst (
		.clk(clk), .rst(rst), .ce(ce),
		.a_exp(a_exp1), .a_sig(a_sig1), .b_exp(b_exp1), .b_sig(b_sig1),
		.big_sig(big_sig3), .small_sig(small_sig3), .big_exp(big_exp3),
		.a_is_big(a_big3), .shifted_sticky(sticky3)
	);

	// Stage 4
	bcd_add_sub #(.DIGITS(DIGITS)) bcd_add_sub_inst (
		.clk(clk), .rst(rst), .ce(ce), .sub(side3[SIDE_SUB]),
		.x(big_sig3), .y(small_sig3), .s(sum)
	);

	// ========================================================================
	// Stage 5: sign and special results
	// ========================================================================

	assign {a_sign4, b_sign4, sub4, rm4, nan4, a_inf4, b_inf4} = side4;

	always_comb begin
		// Subtracted sticky part makes the true value sit just under sum
		r_sig     = (sub4 && sticky4) ? bcd_dec(sum) : sum;
		r_exp     = exp4;
		r_sign    = a_big4 ? a_sign4 : b_sign4;
		r_sticky  = sticky4;
		r_special = 1'b0;
		if (nan4 || (a_inf4 && b_inf4 && sub4)) begin
			r_sign    = 1'b0;
			r_exp     = SPECIAL_EXP;
			r_sig     = NAN_SIG;
			r_sticky  = 1'b0;
			r_special = 1'b1;
		end else if (a_inf4 || b_inf4) begin
			r_sign    = a_inf4 ? a_sign4 : b_sign4;
			r_exp     = SPECIAL_EXP;
			r_sig     = '0;
			r_sticky  = 1'b0;
			r_special = 1'b1;
		end else if ((sum == '0) && !sticky4) begin
			// Exact zero, minus only when both agree or rounding down
			r_sign    = (a_sign4 == b_sign4) ? a_sign4 : (rm4 == rm_toward_neg);
			r_exp     = '0;
			r_sig     = '0;
			r_special = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			w_sign    <= 1'b0;
			w_exp     <= '0;
			w_sig     <= '0;
			w_sticky  <= 1'b0;
			w_special <= 1'b0;
			w_rm      <= rm_nearest_even;
		end else if (ce) begin
			w_sign    <= r_sign;
			w_exp     <= r_exp;
			w_sig     <= r_sig;
			w_sticky  <= r_sticky;
			w_special <= r_special;
			w_rm      <= dfp_rm_e'(rm4);
		end
	end

	// An unknown mode would round silently wrong five stages later
	assert property (@(posedge clk) disable iff (rst) ce |-> !$isunknown(rm));

endmodule

/* logic/dfp_normround.sv */
`timescale 1ns/1ps

module dfp_normround import dfp_pkg::*; #(
	parameter int DIGITS = 7,
	parameter int EXP_W  = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  logic w_sign,
	input  logic [EXP_W-1:0] w_exp,
	input  logic [(DIGITS+WORK_DIGITS_EXTRA+1)*BCD_DIGIT_W-1:0] w_sig,
	input  logic w_sticky,
	input  logic w_special,
	input  dfp_rm_e w_rm,
	output logic o_sign,
	output logic [EXP_W-1:0] o_exp,
	output logic [DIGITS*BCD_DIGIT_W-1:0] o_sig,
	output logic o_inexact
);

	localparam int SIG_W = DIGITS * BCD_DIGIT_W;
	localparam int N_W   = (DIGITS + WORK_DIGITS_EXTRA) * BCD_DIGIT_W;
	localparam int W_W   = N_W + BCD_DIGIT_W;
	localparam int LZ_W  = $clog2(DIGITS + WORK_DIGITS_EXTRA + 1);
	localparam logic [EXP_W-1:0] SPECIAL_EXP = '1;

	logic [BCD_DIGIT_W-1:0] carry_dig;
	logic [N_W-1:0] low;
	logic [LZ_W-1:0] lz, sh;
	// Stage 6 state, exponent one bit wider to see overflow
	logic n_sign, n_sticky, n_special;
	logic [EXP_W:0] n_exp;
	logic [N_W-1:0] n_sig;
	dfp_rm_e n_rm;
	// Stage 7 rounding terms
	logic [SIG_W-1:0] kept, inc_sig, r_sig;
	logic [BCD_DIGIT_W-1:0] guard, round;
	logic rest_nz, disc_nz, inc, inc_carry, ovf;
	logic [EXP_W:0] r_exp;

	function automatic logic [LZ_W-1:0] lead_zeros(input logic [N_W-1:0] v);
		logic [LZ_W-1:0] n;
		logic found;
		n = '0;
		found = 1'b0;
		for (int i = N_W / BCD_DIGIT_W - 1; i >= 0; i--) begin
			if (!found && (v[i*BCD_DIGIT_W +: BCD_DIGIT_W] == '0)) begin
				n = n + 1'b1;
			end else begin
				found = 1'b1;
			end
		end
		return n;
	endfunction

	// Carry out on top, digits below
	function automatic logic [SIG_W:0] bcd_inc(input logic [SIG_W-1:0] v);
		logic [SIG_W-1:0] r;
		logic c;
		r = v;
		c = 1'b1;
		for (int i = 0; i < DIGITS; i++) begin
			if (c) begin
				if (v[i*BCD_DIGIT_W +: BCD_DIGIT_W] == 4'd9) begin
					r[i*BCD_DIGIT_W +: BCD_DIGIT_W] = '0;
				end else begin
					r[i*BCD_DIGIT_W +: BCD_DIGIT_W] = v[i*BCD_DIGIT_W +: BCD_DIGIT_W] + 1'b1;
					c = 1'b0;
				end
			end
		end
		return {c, r};
	endfunction

	// ========================================================================
	// Stage 6: normalize
	// ========================================================================

	assign carry_dig = w_sig[W_W-1 -: BCD_DIGIT_W];
	assign low       = w_sig[N_W-1:0];
	assign lz        = lead_zeros(low);
	// Left shift stops once the exponent reaches 0
	assign sh        = (w_exp < lz) ? LZ_W'(w_exp) : lz;

	always_ff @(posedge clk) begin
		if (rst) begin
			n_sign    <= 1'b0;
			n_exp     <= '0;
			n_sig     <= '0;
			n_sticky  <= 1'b0;
			n_special <= 1'b0;
			n_rm      <= rm_nearest_even;
		end else if (ce) begin
			n_sign    <= w_sign;
			n_special <= w_special;
			n_rm      <= w_rm;
			if (w_special) begin
				n_exp    <= {1'b0, w_exp};
				n_sig    <= low;
				n_sticky <= 1'b0;
			end else if (carry_dig != '0) begin
				// Round digit falls into sticky
				n_exp    <= {1'b0, w_exp} + 1'b1;
				n_sig    <= w_sig[W_W-1:BCD_DIGIT_W];
				n_sticky <= w_sticky | (w_sig[BCD_DIGIT_W-1:0] != '0);
			end else begin
				n_exp    <= {1'b0, w_exp} - sh;
				n_sig    <= low << (sh * BCD_DIGIT_W);
				n_sticky <= w_sticky;
			end
		end
	end

	// ========================================================================
	// Stage 7: round and overflow
	// ========================================================================

	assign kept    = n_sig[N_W-1 -: SIG_W];
	assign guard   = n_sig[2*BCD_DIGIT_W-1 -: BCD_DIGIT_W];
	assign round   = n_sig[BCD_DIGIT_W-1:0];
	assign rest_nz = (round != '0) || n_sticky;
	assign disc_nz = (guard != '0) || rest_nz;

	always_comb begin
		case (n_rm)
			// Above half, or a tie onto an odd last digit
			rm_nearest_even: inc = (guard > 4'd5) || ((guard == 4'd5) && (rest_nz || kept[0]));
			rm_toward_zero:  inc = 1'b0;
			rm_toward_pos:   inc = !n_sign && disc_nz;
			rm_toward_neg:   inc = n_sign && disc_nz;
			default:         inc = 1'b0;
		endcase
	end

	assign {inc_carry, inc_sig} = bcd_inc(kept);

	// All nines rolls over to 1 followed by zeros, one decade up
	assign r_sig = !inc ? kept : (inc_carry ? {4'h1, {(SIG_W-BCD_DIGIT_W){1'b0}}} : inc_sig);
	assign r_exp = n_exp + (inc & inc_carry);
	assign ovf   = (r_exp >= {1'b0, SPECIAL_EXP});

	always_ff @(posedge clk) begin
		if (rst) begin
			o_sign    <= 1'b0;
			o_exp     <= '0;
			o_sig     <= '0;
			o_inexact <= 1'b0;
		end else if (ce) begin
			o_sign <= n_sign;
			if (n_special) begin
				o_exp     <= n_exp[EXP_W-1:0];
				o_sig     <= kept;
				o_inexact <= 1'b0;
			end else if (ovf) begin
				// Infinity
				o_exp     <= SPECIAL_EXP;
				o_sig     <= '0;
				o_inexact <= disc_nz;
			end else begin
				o_exp     <= r_exp[EXP_W-1:0];
				o_sig     <= r_sig;
				o_inexact <= disc_nz;
			end
		end
	end

endmodule

/* logic/dfp_addsub_unit.sv */
`timescale 1ns/1ps

module dfp_addsub_unit import dfp_pkg::*; #(
	parameter int DIGITS = 7,
	parameter int EXP_W  = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic ce,
	input  dfp_op_e op,
	input  dfp_rm_e rm,
	input  logic a_sign,
	input  logic [EXP_W-1:0] a_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] a_sig,
	input  logic b_sign,
	input  logic [EXP_W-1:0] b_exp,
	input  logic [DIGITS*BCD_DIGIT_W-1:0] b_sig,
	output logic o_sign,
	output logic [EXP_W-1:0] o_exp,
	output logic [DIGITS*BCD_DIGIT_W-1:0] o_sig,
	output logic o_inexact
);

	// ========================================================================
	// Core result: carry digit, significand, guard, round
	// ========================================================================
	logic w_sign;
	logic [EXP_W-1:0] w_exp;
	logic [(DIGITS+WORK_DIGITS_EXTRA+1)*BCD_DIGIT_W-1:0] w_sig;
	logic w_sticky;
	logic w_special;
	dfp_rm_e w_rm;

	// Five stages of align and add
	dfp_addsub #(.DIGITS(DIGITS), .EXP_W(EXP_W)) dfp_addsub_inst (
		.clk(clk), .rst(rst), .ce(ce), .op(op), .rm(rm),
		.a_sign(a_sign), .a_exp(a_exp), .a_sig(a_sig),
		.b_sign(b_sign), .b_exp(b_exp), .b_sig(b_sig),
		.w_sign(w_sign), .w_exp(w_exp), .w_sig(w_sig),
		.w_sticky(w_sticky), .w_special(w_special), .w_rm(w_rm)
	);

	// Two more to normalize and round
	dfp_normround #(.DIGITS(DIGITS), .EXP_W(EXP_W)) dfp_normround_inst (
		.clk(clk), .rst(rst), .ce(ce),
		.w_sign(w_sign), .w_exp(w_exp), .w_sig(w_sig),
		.w_sticky(w_sticky), .w_special(w_special), .w_rm(w_rm),
		.o_sign(o_sign), .o_exp(o_exp), .o_sig(o_sig), .o_inexact(o_inexact)
	);

endmodule

/* bench/dfp_tb_cases.svh */
// Columns: name, op, rm, operand a, operand b, expected result, expected inexact, gap
// Words are a sign nibble, two exponent hex digits, seven BCD digits
// Gap is the number of ce-low cycles before the row, -1 draws one at random

task automatic load_cases();
	// ========================================================================
	// Plain add and subtract
	// ========================================================================
	add_row("add_simple", op_add, rm_nearest_even, 'h0_40_1234567, 'h0_40_1111111,
		'h0_40_2345678, 1'b0, 0);
	// Carry digit forces a right shift
	add_row("add_carry", op_add, rm_nearest_even, 'h0_40_9000000, 'h0_40_2000000,
		'h0_41_1100000, 1'b0, 0);
	add_row("sub_align", op_sub, rm_nearest_even, 'h0_42_5000000, 'h0_40_1234500,
		'h0_42_4987655, 1'b0, 0);
	// Six leading zeros shift out, exponent drops by six
	add_row("sub_cancel", op_sub, rm_nearest_even, 'h0_40_1234567, 'h0_40_1234560,
		'h0_3A_7000000, 1'b0, 0);
	add_row("sub_sign_flip", op_sub, rm_nearest_even, 'h0_40_1000000, 'h0_40_3000000,
		'h1_40_2000000, 1'b0, 0);
	// ========================================================================
	// Rounding, sum 1269134.89
	// ========================================================================
	add_row("round_ne", op_add, rm_nearest_even, 'h0_40_1234567, 'h0_3E_3456789,
		'h0_40_1269135, 1'b1, 0);
	add_row("round_tz", op_add, rm_toward_zero, 'h0_40_1234567, 'h0_3E_3456789,
		'h0_40_1269134, 1'b1, 0);
	add_row("round_tp", op_add, rm_toward_pos, 'h0_40_1234567, 'h0_3E_3456789,
		'h0_40_1269135, 1'b1, 0);
	add_row("round_tn", op_add, rm_toward_neg, 'h0_40_1234567, 'h0_3E_3456789,
		'h0_40_1269134, 1'b1, 0);
	add_row("round_neg_tn", op_add, rm_toward_neg, 'h1_40_1234567, 'h1_3E_3456789,
		'h1_40_1269135, 1'b1, 0);
	add_row("round_neg_tp", op_add, rm_toward_pos, 'h1_40_1234567, 'h1_3E_3456789,
		'h1_40_1269134, 1'b1, 0);
	// Exact half lands in the guard digit
	add_row("tie_even", op_add, rm_nearest_even, 'h0_40_1234566, 'h0_39_5000000,
		'h0_40_1234566, 1'b1, 0);
	add_row("tie_odd", op_add, rm_nearest_even, 'h0_40_1234567, 'h0_39_5000000,
		'h0_40_1234568, 1'b1, 0);
	// Small operand falls wholly into sticky
	add_row("sub_sticky_ne", op_sub, rm_nearest_even, 'h0_40_1000000, 'h0_36_0000001,
		'h0_40_1000000, 1'b1, 0);
	add_row("sub_sticky_tz", op_sub, rm_toward_zero, 'h0_40_1000000, 'h0_36_0000001,
		'h0_3F_9999999, 1'b1, 0);
	// ========================================================================
	// Exact zero results
	// ========================================================================
	add_row("zero_ne", op_sub, rm_nearest_even, 'h0_40_1234567, 'h0_40_1234567,
		'h0_00_0000000, 1'b0, 0);
	add_row("zero_tn", op_sub, rm_toward_neg, 'h0_40_1234567, 'h0_40_1234567,
		'h1_00_0000000, 1'b0, 0);
	add_row("zero_neg_sum", op_add, rm_nearest_even, 'h1_40_0000000, 'h1_40_0000000,
		'h1_00_0000000, 1'b0, 0);
	// ========================================================================
	// Infinity, NaN and overflow
	// ========================================================================
	add_row("nan_a", op_add, rm_nearest_even, 'h0_FF_0000001, 'h0_40_1234567,
		'h0_FF_0000001, 1'b0, 0);
	add_row("nan_b", op_sub, rm_toward_neg, 'h1_40_1234567, 'h1_FF_0000042,
		'h0_FF_0000001, 1'b0, 0);
	add_row("inf_plus_fin", op_add, rm_nearest_even, 'h0_FF_0000000, 'h1_40_1234567,
		'h0_FF_0000000, 1'b0, 0);
	add_row("fin_minus_inf", op_sub, rm_nearest_even, 'h0_40_1234567, 'h0_FF_0000000,
		'h1_FF_0000000, 1'b0, 0);
	add_row("inf_minus_inf", op_sub, rm_nearest_even, 'h0_FF_0000000, 'h0_FF_0000000,
		'h0_FF_0000001, 1'b0, 0);
	add_row("neg_inf_sum", op_add, rm_nearest_even, 'h1_FF_0000000, 'h1_FF_0000000,
		'h1_FF_0000000, 1'b0, 0);
	add_row("ovf_round", op_add, rm_nearest_even, 'h0_FE_9999999, 'h0_F7_9000000,
		'h0_FF_0000000, 1'b1, 0);
	add_row("ovf_tz_edge", op_add, rm_toward_zero, 'h0_FE_9999999, 'h0_F7_9000000,
		'h0_FE_9999999, 1'b1, 0);
	add_row("ovf_carry", op_add, rm_nearest_even, 'h0_FE_5000000, 'h0_FE_5000000,
		'h0_FF_0000000, 1'b0, 0);
	// ========================================================================
	// Repeats behind ce-low stalls
	// ========================================================================
	add_row("stall_add", op_add, rm_nearest_even, 'h0_40_1234567, 'h0_40_1111111,
		'h0_40_2345678, 1'b0, 3);
	add_row("stall_cancel", op_sub, rm_nearest_even, 'h0_40_1234567, 'h0_40_1234560,
		'h0_3A_7000000, 1'b0, 1);
	add_row("stall_round", op_add, rm_nearest_even, 'h0_40_1234567, 'h0_3E_3456789,
		'h0_40_1269135, 1'b1, -1);
	add_row("stall_sticky", op_sub, rm_toward_zero, 'h0_40_1000000, 'h0_36_0000001,
		'h0_3F_9999999, 1'b1, 2);
	add_row("stall_nan", op_sub, rm_nearest_even, 'h0_FF_0000000, 'h0_FF_0000000,
		'h0_FF_0000001, 1'b0, -1);
endtask

/* bench/dfp_tb.sv */
`timescale 1ns/1ps

module dfp_tb import dfp_pkg::*; ();

	localparam int DIGITS       = 7;
	localparam int EXP_W        = 8;
	localparam int SIG_W        = DIGITS * BCD_DIGIT_W;
	localparam int LATENCY      = 7;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_GAP      = 3;

	logic clk;
	logic rst;
	logic ce;
	dfp_op_e op;
	dfp_rm_e rm;
	logic a_sign;
	logic [EXP_W-1:0] a_exp;
	logic [SIG_W-1:0] a_sig;
	logic b_sign;
	logic [EXP_W-1:0] b_exp;
	logic [SIG_W-1:0] b_sig;
	logic o_sign;
	logic [EXP_W-1:0] o_exp;
	logic [SIG_W-1:0] o_sig;
	logic o_inexact;

	// Case table, one entry per row
	string       case_name[$];
	dfp_op_e     case_op[$];
	dfp_rm_e     case_rm[$];
	logic [39:0] case_a[$];
	logic [39:0] case_b[$];
	logic [39:0] case_res[$];
	logic        case_inx[$];
	int          case_gap[$];

	// Row index held in each pipeline stage, -1 is a bubble
	int stage_tag[LATENCY];
	int pass_count;
	int fail_count;
	int cycle_count;
	int cycle_limit;
	integer seed;

	dfp_addsub_unit #(.DIGITS(DIGITS), .EXP_W(EXP_W)) dfp_addsub_unit_inst (
		.clk(clk), .rst(rst), .ce(ce), .op(op), .rm(rm),
		.a_sign(a_sign), .a_exp(a_exp), .a_sig(a_sig),
		.b_sign(b_sign), .b_exp(b_exp), .b_sig(b_sig),
		.o_sign(o_sign), .o_exp(o_exp), .o_sig(o_sig), .o_inexact(o_inexact)
	);

	// 40 ns period
	always #20 clk = ~clk;

	task automatic add_row(input string name, input dfp_op_e o, input dfp_rm_e m,
		input logic [39:0] a, input logic [39:0] b, input logic [39:0] res,
		input logic inx, input int gap);
		case_name.push_back(name);
		case_op.push_back(o);
		case_rm.push_back(m);
		case_a.push_back(a);
		case_b.push_back(b);
		case_res.push_back(res);
		case_inx.push_back(inx);
		case_gap.push_back(gap);
	endtask

	`include "dfp_tb_cases.svh"

	// Sign, significand, exponent and flag in one readable field
	function automatic string describe(input logic [39:0] w, input logic inx);
		return $sformatf("%s%07h e%02h inexact %0b", w[36] ? "-" : "+",
			w[27:0], w[35:28], inx);
	endfunction

	task automatic drive_row(input int r);
		op     = case_op[r];
		rm     = case_rm[r];
		a_sign = case_a[r][36];
		a_exp  = case_a[r][35:28];
		a_sig  = case_a[r][27:0];
		b_sign = case_b[r][36];
		b_exp  = case_b[r][35:28];
		b_sig  = case_b[r][27:0];
	endtask

	// Two positive zeros
	task automatic drive_idle();
		op     = op_add;
		rm     = rm_nearest_even;
		a_sign = 1'b0;
		a_exp  = '0;
		a_sig  = '0;
		b_sign = 1'b0;
		b_exp  = '0;
		b_sig  = '0;
	endtask

	// Junk on the inputs while ce is low, none of it may enter the pipe
	task automatic drive_noise();
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		r0     = $random(seed);
		r1     = $random(seed);
		r2     = $random(seed);
		op     = dfp_op_e'(r0[0]);
		rm     = dfp_rm_e'(r0[2:1]);
		a_sign = r0[3];
		b_sign = r0[4];
		a_exp  = r0[15:8];
		b_exp  = r0[23:16];
		a_sig  = r1[27:0];
		b_sig  = r2[27:0];
	endtask

	task automatic check_row(input int r);
		logic [39:0] got;
		got = {3'b000, o_sign, o_exp, o_sig};
		if ((got !== case_res[r]) || (o_inexact !== case_inx[r])) begin
			fail_count++;
			$display("MISMATCH %s expected %s actual %s", case_name[r],
				describe(case_res[r], case_inx[r]), describe(got, o_inexact));
		end else begin
			pass_count++;
			$display("ok       %s  %s", case_name[r], describe(got, o_inexact));
		end
	endtask

	// Called after each enabled edge, the oldest tag has reached the outputs
	task automatic advance_pipe(input int tag);
		for (int i = LATENCY - 1; i > 0; i--) begin
			stage_tag[i] = stage_tag[i-1];
		end
		stage_tag[0] = tag;
		if (stage_tag[LATENCY-1] >= 0) begin
			check_row(stage_tag[LATENCY-1]);
		end
	endtask

	function automatic logic any_pending();
		logic busy;
		busy = 1'b0;
		for (int i = 0; i < LATENCY; i++) begin
			if (stage_tag[i] >= 0) begin
				busy = 1'b1;
			end
		end
		return busy;
	endfunction

	// ========================================================================
	// Stimulus and checking
	// ========================================================================
	initial begin
		int gap;
		clk         = 1'b0;
		rst         = 1'b1;
		ce          = 1'b0;
		seed        = 90;
		pass_count  = 0;
		fail_count  = 0;
		cycle_count = 0;
		drive_idle();
		for (int i = 0; i < LATENCY; i++) begin
			stage_tag[i] = -1;
		end
		load_cases();
		// Worst case every row waits the longest gap
		cycle_limit = RESET_CYCLES + case_name.size() * 4 + 50;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Registers cleared to a positive zero
		if ({o_sign, o_exp, o_sig, o_inexact} !== '0) begin
			fail_count++;
			$display("MISMATCH reset_zero expected %s actual %s",
				describe('0, 1'b0), describe({3'b000, o_sign, o_exp, o_sig}, o_inexact));
		end else begin
			pass_count++;
			$display("ok       reset_zero");
		end

		// Rows stream back to back apart from their gaps
		for (int r = 0; r < case_name.size(); r++) begin
			gap = case_gap[r];
			if (gap < 0) begin
				gap = $unsigned($random(seed)) % (MAX_GAP + 1);
			end
			repeat (gap) begin
				ce = 1'b0;
				drive_noise();
				@(negedge clk);
			end
			ce = 1'b1;
			drive_row(r);
			@(negedge clk);
			advance_pipe(r);
		end

		// Flush the last results out with bubbles
		while (any_pending()) begin
			ce = 1'b1;
			drive_idle();
			@(negedge clk);
			advance_pipe(-1);
		end
		ce = 1'b0;

		$display("Summary: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// Cycle counter guards against a stuck run
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

/* flist.f */
+incdir+bench
logic/dfp_pkg.sv
logic/bcd_add_sub.sv
logic/dfp_align.sv
logic/dfp_addsub.sv
logic/dfp_normround.sv
logic/dfp_addsub_unit.sv
bench/dfp_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the decimal add/sub testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f flist.f --top-module dfp_tb --Mdir "$BUILD_DIR" -o dfp_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/dfp_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
	exit 0
fi
echo "Pass message not found in $LOG"
exit 1
